// File: src/fp_cmp_params.svh
// floating-point comparison width parameters.
// operand width default and the exponent and mantissa field sizes that follow from it.
`ifndef FP_CMP_PARAMS_SVH
`define FP_CMP_PARAMS_SVH

// default operand width in bits.
// the subsystem handles half, single and double precision.
`define FP_WID 32

// most significant bit index of the biased exponent field.
// half precision has 5 exponent bits, single has 8 and double has 11.
// any width other than 32 or 64 falls back to the half precision layout.
`define FP_EMSB(w) ((w) == 64 ? 10 : (w) == 32 ? 7 : 4)

// most significant bit index of the stored mantissa field.
// the hidden leading one is not part of the stored field.
// half precision stores 10 bits, single stores 23 and double stores 52.
`define FP_FMSB(w) ((w) == 64 ? 51 : (w) == 32 ? 22 : 9)

// for every supported width the sign bit, the exponent field and the mantissa
// field together fill the operand exactly.
// the sign sits in the top bit.
// the exponent follows directly below it.
// the mantissa takes the remaining low bits.
// a caller that adds a new width has to extend both field macros together,
// otherwise the slices in the decoder no longer line up with the operand.

`endif

// File: src/fp_cmp_pkg.sv
// floating-point comparison package.
// holds the opcode type shared by the comparison unit, the top level and the testbench.
`default_nettype none

package fp_cmp_pkg;

	// comparison opcodes.
	// the encoding matches the 3-bit opcode field of the existing compare unit.
	// the low six codes are ordered predicates and raise the NaN exception
	// when either operand is a NaN.
	// the top two codes test the ordering itself and never raise it.
	typedef enum logic [2:0] {
		// a is strictly less than b.
		op_lt = 3'd0,
		// a is greater than or equal to b.
		op_ge = 3'd1,
		// a is less than or equal to b.
		op_le = 3'd2,
		// a is strictly greater than b.
		op_gt = 3'd3,
		// a equals b, with +0 and -0 treated as equal.
		op_eq = 3'd4,
		// a differs from b.
		op_ne = 3'd5,
		// at least one operand is a NaN.
		op_un = 3'd6,
		// neither operand is a NaN.
		op_or = 3'd7
	} cmp_op_e;

	// note that op_ge and op_gt are the complements of op_lt and op_le.
	// op_ne is the complement of op_eq, and op_or is the complement of op_un.
	// the comparison unit relies on these pairings to share one less-than
	// and one equality term across all eight predicates.

endpackage

`default_nettype wire

// File: src/fp_decomp.sv
// floating-point operand decoder.
// splits one IEEE 754 value into its fields and classifies it.
`timescale 1ns/1ns
`default_nettype none

`include "fp_cmp_params.svh"

module fp_decomp #(
	parameter int WID = `FP_WID
) (
	input  logic [WID-1:0]         i,
	output logic                   sgn,
	output logic [`FP_EMSB(WID):0] exp,
	output logic [`FP_FMSB(WID):0] man,
	output logic                   vz,
	output logic                   inf,
	output logic                   qnan,
	output logic                   snan,
	output logic                   nan
);

	localparam int EMSB = `FP_EMSB(WID);
	localparam int FMSB = `FP_FMSB(WID);

	// field summaries shared by the class decisions below.
	logic exp_ones;
	logic exp_zero;
	logic man_zero;

	// only the three IEEE interchange widths are laid out by the field macros.
	if (WID != 16 && WID != 32 && WID != 64) begin : g_bad_wid
		$error("fp_decomp: unsupported operand width %0d", WID);
	end

	// the sign is the top bit.
	// the exponent sits right below it and the mantissa fills the rest.
	assign sgn = i[WID-1];
	assign exp = i[WID-2 -: EMSB+1];
	assign man = i[FMSB:0];

	assign exp_ones = &exp;
	assign exp_zero = ~|exp;
	assign man_zero = ~|man;

	// a zero has both fields clear, whatever its sign.
	// denormals keep a nonzero mantissa and so are not zero here.
	assign vz = exp_zero & man_zero;

	// an all-ones exponent with an empty mantissa is infinity.
	assign inf = exp_ones & man_zero;

	// an all-ones exponent with any mantissa bit set is a NaN.
	assign nan = exp_ones & ~man_zero;

	// the top mantissa bit tells a quiet NaN from a signaling one.
	assign qnan = nan & man[FMSB];
	assign snan = nan & ~man[FMSB];

	// the three classes come from disjoint field patterns.
	// the zero class is also held against the raw operand below the sign,
	// so a field slice that leaves a bit out shows up here.
	always_comb begin
		if (!$isunknown(i)) begin
			a_class_excl: assert #0 ($onehot0({vz, inf, nan}) && (vz == ~|i[WID-2:0]))
				else $error("fp_decomp: operand %h classified inconsistently", i);
		end
	end

endmodule

`default_nettype wire

// File: src/fp_cmp_unit.sv
// floating-point predicate unit.
// joins two operand decodes under a comparison opcode into a predicate and a NaN exception.
`timescale 1ns/1ns
`default_nettype none

`include "fp_cmp_params.svh"

module fp_cmp_unit #(
	parameter int WID = `FP_WID
) (
	input  fp_cmp_pkg::cmp_op_e    op,
	input  logic [WID-1:0]         a,
	input  logic [WID-1:0]         b,
	input  logic                   sa,
	input  logic                   sb,
	input  logic [`FP_EMSB(WID):0] xa,
	input  logic [`FP_EMSB(WID):0] xb,
	input  logic [`FP_FMSB(WID):0] ma,
	input  logic [`FP_FMSB(WID):0] mb,
	input  logic                   az,
	input  logic                   bz,
	input  logic                   nan_a,
	input  logic                   nan_b,
	output logic                   o,
	output logic                   nanx
);

	localparam int EMSB = `FP_EMSB(WID);
	localparam int FMSB = `FP_FMSB(WID);

	// the three base relations that every opcode is built from.
	logic unordered;
	logic eq;
	logic lt;

	// magnitude order of the exponent and mantissa concatenation.
	// with a biased exponent this is the order of the absolute values.
	logic mag_lt;
	logic mag_gt;

	// both zeros, regardless of sign.
	logic both_zero;

	// NaN test taken straight from the raw operands, apart from the decoders.
	logic raw_unord;

	// unordered when either side is a NaN.
	assign unordered = nan_a | nan_b;

	assign both_zero = az & bz;

	// equal when both are zero or the bit patterns match.
	// a NaN never equals anything, itself included, so the ordered check gates it.
	assign eq = ~unordered & (both_zero | (a == b));

	assign mag_lt = {xa, ma} < {xb, mb};
	assign mag_gt = {xa, ma} > {xb, mb};

	// with different signs the negative side is less, unless both are zero.
	// with equal signs the magnitudes decide, and a negative pair reverses them.
	always_comb begin
		if (sa ^ sb) begin
			lt = sa & ~both_zero;
		end else if (sa) begin
			lt = mag_gt;
		end else begin
			lt = mag_lt;
		end
	end

	// predicate selection.
	// ge, gt and ne are complements of lt, le and eq.
	always_comb begin
		case (op)
			fp_cmp_pkg::op_lt: o = lt;
			fp_cmp_pkg::op_ge: o = ~lt;
			fp_cmp_pkg::op_le: o = lt | eq;
			fp_cmp_pkg::op_gt: o = ~(lt | eq);
			fp_cmp_pkg::op_eq: o = eq;
			fp_cmp_pkg::op_ne: o = ~eq;
			fp_cmp_pkg::op_un: o = unordered;
			fp_cmp_pkg::op_or: o = ~unordered;
			default:           o = 1'b0;
		endcase
	end

	// an ordered predicate on a NaN operand signals the exception.
	// both NaN kinds count here.
	// the two ordering tests are the only opcodes that stay quiet.
	assign nanx = unordered & (op != fp_cmp_pkg::op_un) & (op != fp_cmp_pkg::op_or);

	assign raw_unord = (&a[WID-2 -: EMSB+1] & |a[FMSB:0])
		| (&b[WID-2 -: EMSB+1] & |b[FMSB:0]);

	// the unit has no clock, so the checks run once the inputs have settled.
	// both are held against the raw operands, so a wrong decode on the way in shows up.
	always_comb begin
		if (!$isunknown({op, a, b})) begin
			// the exception is only ever raised for an unordered pair.
			a_nanx_unord: assert #0 (!nanx || raw_unord)
				else $error("fp_cmp_unit: nanx without a NaN operand, a=%h b=%h", a, b);
			// an equality test on a NaN pair must report not equal.
			a_eq_nanx: assert #0 (!(op == fp_cmp_pkg::op_eq && o && raw_unord))
				else $error("fp_cmp_unit: op_eq true on a NaN pair, a=%h b=%h", a, b);
		end
	end

endmodule

`default_nettype wire

// File: src/fp_cmp_top.sv
// floating-point comparison top level.
// samples an operand pair, decodes and compares it, and registers the result with a sticky NaN flag.
`timescale 1ns/1ns
`default_nettype none

`include "fp_cmp_params.svh"

module fp_cmp_top #(
	parameter int WID = `FP_WID
) (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                in_valid,
	input  fp_cmp_pkg::cmp_op_e op,
	input  logic [WID-1:0]      a,
	input  logic [WID-1:0]      b,
	input  logic                clear,
	output logic                out_valid,
	output logic                result,
	output logic                nan_exc,
	output logic                nan_sticky
);

	// operand stage.
	fp_cmp_pkg::cmp_op_e op_q;
	logic [WID-1:0]      a_q;
	logic [WID-1:0]      b_q;
	logic                pend;

	// decoded fields of both operands.
	logic                   sa;
	logic                   sb;
	logic [`FP_EMSB(WID):0] xa;
	logic [`FP_EMSB(WID):0] xb;
	logic [`FP_FMSB(WID):0] ma;
	logic [`FP_FMSB(WID):0] mb;
	logic                   az;
	logic                   bz;
	logic                   nan_a;
	logic                   nan_b;

	// combinational compare outputs, captured by the result stage.
	logic cmp_o;
	logic cmp_nanx;

	// the pending bit marks a valid pair in the operand stage.
	// the inputs are not held by the outside, so they are captured on the strobe.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pend <= 1'b0;
		end else begin
			pend <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			op_q <= op;
			a_q  <= a;
			b_q  <= b;
		end
	end

	// the class outputs not needed by the predicate stay open.
	fp_decomp #(.WID(WID)) u_dec_a (
		.i(a_q), .sgn(sa), .exp(xa), .man(ma), .vz(az),
		.inf(), .qnan(), .snan(), .nan(nan_a)
	);

	fp_decomp #(.WID(WID)) u_dec_b (
		.i(b_q), .sgn(sb), .exp(xb), .man(mb), .vz(bz),
		.inf(), .qnan(), .snan(), .nan(nan_b)
	);

	fp_cmp_unit #(.WID(WID)) u_cmp (
		.op(op_q), .a(a_q), .b(b_q),
		.sa(sa), .sb(sb), .xa(xa), .xb(xb), .ma(ma), .mb(mb),
		.az(az), .bz(bz), .nan_a(nan_a), .nan_b(nan_b),
		.o(cmp_o), .nanx(cmp_nanx)
	);

	// result stage.
	// out_valid is a one-cycle pulse per pair and the data holds until the next one.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			result    <= 1'b0;
			nan_exc   <= 1'b0;
		end else begin
			out_valid <= pend;
			if (pend) begin
				result  <= cmp_o;
				nan_exc <= cmp_nanx;
			end
		end
	end

	// the sticky flag sets together with a raised nan_exc.
	// a new exception beats a clear on the same edge.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			nan_sticky <= 1'b0;
		end else if (pend && cmp_nanx) begin
			nan_sticky <= 1'b1;
		end else if (clear) begin
			nan_sticky <= 1'b0;
		end
	end

	// every strobe produces a result exactly one cycle after its sampling edge.
	a_strobe_to_valid: assert property (@(posedge clk) disable iff (!arst_n)
		in_valid |-> ##2 out_valid);

	// each result cycle is backed by a strobe two samples earlier.
	a_valid_has_strobe: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |-> $past(in_valid, 2));

	// the flag only comes up on a delivered exception.
	a_sticky_rise: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(nan_sticky) |-> (out_valid && nan_exc));

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
// testbench clock and reset generator.
// free running clock with an active low reset held for a fixed number of cycles.
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD     = 10,
	parameter int RST_CYCLES = 3
) (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// reset is released on a falling edge so it never races a sampling edge.
	initial begin
		arst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: tb/tb_fp_cmp.sv
// testbench for the floating-point comparison top level.
// random and directed operand pairs checked against a reference model at single precision.
`timescale 1ns/1ns
`default_nettype none

module tb_fp_cmp;

	localparam int WID         = 32;
	localparam int N_RANDOM    = 600;
	localparam int N_DIRECTED  = 32;
	localparam int NUM_STROBES = N_DIRECTED + N_RANDOM;
	localparam int TIMEOUT_CYCLES = NUM_STROBES * 2 + 50;

	// frequently used single precision constants.
	localparam logic [31:0] POS_ZERO = 32'h0000_0000;
	localparam logic [31:0] NEG_ZERO = 32'h8000_0000;
	localparam logic [31:0] POS_ONE  = 32'h3F80_0000;
	localparam logic [31:0] NEG_ONE  = 32'hBF80_0000;
	localparam logic [31:0] POS_TWO  = 32'h4000_0000;
	localparam logic [31:0] NEG_TWO  = 32'hC000_0000;
	localparam logic [31:0] NEG_INF  = 32'hFF80_0000;
	localparam logic [31:0] QNAN     = 32'h7FC0_0000;
	localparam logic [31:0] SNAN     = 32'h7F80_0001;

	logic                clk;
	logic                arst_n;
	logic                in_valid;
	fp_cmp_pkg::cmp_op_e op;
	logic [WID-1:0]      a;
	logic [WID-1:0]      b;
	logic                clear;
	logic                out_valid;
	logic                result;
	logic                nan_exc;
	logic                nan_sticky;

	// expected results wait here from their strobe until their out_valid cycle.
	logic  exp_res_q[$];
	logic  exp_nan_q[$];
	string name_q[$];

	// drive history, index 0 is the value driven on the latest falling edge.
	logic v_d0;
	logic v_d1;
	logic v_d2;
	logic clr_d0;
	logic clr_d1;

	// model state of the result register and the sticky flag.
	logic  m_result;
	logic  m_nan;
	logic  m_sticky;
	string m_name;

	integer seed;
	int     n_errors;
	int     cycle_cnt;

	tb_clk_gen #(.PERIOD(10), .RST_CYCLES(3)) u_clk_gen (
		.clk(clk),
		.arst_n(arst_n)
	);

	fp_cmp_top #(.WID(WID)) dut (
		.clk(clk), .arst_n(arst_n), .in_valid(in_valid), .op(op),
		.a(a), .b(b), .clear(clear),
		.out_valid(out_valid), .result(result), .nan_exc(nan_exc), .nan_sticky(nan_sticky)
	);

	// the run is bounded by the number of strobes plus some slack for idle cycles.
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the test sequence did not complete", cycle_cnt);
			$display("=== FAIL ===");
			$fatal(1, "simulation timed out");
		end
	end

	task automatic check_result(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			n_errors++;
			$display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "predicate mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			n_errors++;
			$display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "flag mismatch");
		end
	endtask

	// reference model of the predicate and the NaN exception for single precision.
	// sign in bit 31, an 8-bit biased exponent and a 23-bit stored mantissa.
	task automatic ref_compare(input fp_cmp_pkg::cmp_op_e op_i, input logic [31:0] x,
			input logic [31:0] y, output logic o, output logic nx);
		logic x_nan;
		logic y_nan;
		logic x_zero;
		logic y_zero;
		logic unord;
		logic eq;
		logic lt;
		x_nan  = (x[30:23] == 8'hFF) && (x[22:0] != 0);
		y_nan  = (y[30:23] == 8'hFF) && (y[22:0] != 0);
		x_zero = (x[30:0] == 0);
		y_zero = (y[30:0] == 0);
		unord  = x_nan || y_nan;
		eq     = !unord && ((x_zero && y_zero) || (x == y));
		// the magnitude order of exponent and mantissa flips for two negatives.
		if (x[31] != y[31]) begin
			lt = x[31] && !(x_zero && y_zero);
		end else if (x[31]) begin
			lt = x[30:0] > y[30:0];
		end else begin
			lt = x[30:0] < y[30:0];
		end
		case (op_i)
			fp_cmp_pkg::op_lt: o = lt;
			fp_cmp_pkg::op_ge: o = !lt;
			fp_cmp_pkg::op_le: o = lt || eq;
			fp_cmp_pkg::op_gt: o = !(lt || eq);
			fp_cmp_pkg::op_eq: o = eq;
			fp_cmp_pkg::op_ne: o = !eq;
			fp_cmp_pkg::op_un: o = unord;
			default:           o = !unord;
		endcase
		nx = unord && (op_i != fp_cmp_pkg::op_un) && (op_i != fp_cmp_pkg::op_or);
	endtask

	// runs on each falling edge before new inputs are driven.
	// the edge that just passed delivered the strobe driven two falling edges ago.
	task automatic check_outputs();
		v_d2   = v_d1;
		v_d1   = v_d0;
		clr_d1 = clr_d0;
		check_flag({m_name, " out_valid timing"}, v_d2, out_valid);
		if (v_d2) begin
			m_name   = name_q.pop_front();
			m_result = exp_res_q.pop_front();
			m_nan    = exp_nan_q.pop_front();
		end
		// a delivered exception beats a clear sampled on the same edge.
		if (v_d2 && m_nan) begin
			m_sticky = 1'b1;
		end else if (clr_d1) begin
			m_sticky = 1'b0;
		end
		check_result(m_name, m_result, result);
		check_flag({m_name, " nan_exc"}, m_nan, nan_exc);
		check_flag({m_name, " nan_sticky"}, m_sticky, nan_sticky);
	endtask

	// one clock cycle: check on the falling edge, then drive the next inputs.
	task automatic drive_cycle(input logic v, input fp_cmp_pkg::cmp_op_e op_i,
			input logic [31:0] a_i, input logic [31:0] b_i, input logic clr, input string name);
		logic exp_o;
		logic exp_nx;
		@(negedge clk);
		check_outputs();
		if (v) begin
			ref_compare(op_i, a_i, b_i, exp_o, exp_nx);
			exp_res_q.push_back(exp_o);
			exp_nan_q.push_back(exp_nx);
			name_q.push_back(name);
		end
		in_valid = v;
		op       = op_i;
		a        = a_i;
		b        = b_i;
		clear    = clr;
		v_d0     = v;
		clr_d0   = clr;
	endtask

	task automatic idle_cycles(input int n, input logic clr);
		for (int k = 0; k < n; k++) begin
			drive_cycle(1'b0, fp_cmp_pkg::op_lt, POS_ZERO, POS_ZERO, clr, "idle");
		end
	endtask

	// about a quarter of the operands are special values or a copy of the other side.
	task automatic pick_operand(input logic [31:0] other, output logic [31:0] val);
		logic [31:0] r;
		r = $random(seed);
		if (r[31:30] == 2'b00) begin
			case (r[2:0])
				3'd0: val = {r[3], 31'h0};
				3'd1: val = {r[3], 8'hFF, 23'h0};
				3'd2: val = {r[3], 8'hFF, 1'b1, r[25:4]};
				3'd3: val = {r[3], 8'hFF, 1'b0, r[24:4], 1'b1};
				default: val = other;
			endcase
		end else begin
			val = $random(seed);
		end
	endtask

	initial begin
		logic [31:0]         r;
		logic [31:0]         a_r;
		logic [31:0]         b_r;
		fp_cmp_pkg::cmp_op_e op_r;
		in_valid  = 1'b0;
		op        = fp_cmp_pkg::op_lt;
		a         = '0;
		b         = '0;
		clear     = 1'b0;
		seed      = 32;
		n_errors  = 0;
		cycle_cnt = 0;
		v_d0      = 1'b0;
		v_d1      = 1'b0;
		v_d2      = 1'b0;
		clr_d0    = 1'b0;
		clr_d1    = 1'b0;
		m_result  = 1'b0;
		m_nan     = 1'b0;
		m_sticky  = 1'b0;
		m_name    = "after reset";
		@(posedge arst_n);

		// all outputs read zero before the first strobe.
		idle_cycles(2, 1'b0);

		// signed zeros are equal, and negative values order in reverse magnitude.
		drive_cycle(1'b1, fp_cmp_pkg::op_eq, POS_ZERO, NEG_ZERO, 1'b0, "+0 eq -0");
		drive_cycle(1'b1, fp_cmp_pkg::op_le, POS_ZERO, NEG_ZERO, 1'b0, "+0 le -0");
		drive_cycle(1'b1, fp_cmp_pkg::op_ge, POS_ZERO, NEG_ZERO, 1'b0, "+0 ge -0");
		drive_cycle(1'b1, fp_cmp_pkg::op_lt, POS_ZERO, NEG_ZERO, 1'b0, "+0 lt -0");
		drive_cycle(1'b1, fp_cmp_pkg::op_gt, POS_ZERO, NEG_ZERO, 1'b0, "+0 gt -0");
		drive_cycle(1'b1, fp_cmp_pkg::op_eq, NEG_ZERO, POS_ZERO, 1'b0, "-0 eq +0");
		drive_cycle(1'b1, fp_cmp_pkg::op_lt, NEG_ZERO, POS_ZERO, 1'b0, "-0 lt +0");
		drive_cycle(1'b1, fp_cmp_pkg::op_gt, NEG_ZERO, POS_ZERO, 1'b0, "-0 gt +0");
		drive_cycle(1'b1, fp_cmp_pkg::op_lt, NEG_ONE, NEG_TWO, 1'b0, "-1 lt -2");
		drive_cycle(1'b1, fp_cmp_pkg::op_gt, NEG_ONE, NEG_TWO, 1'b0, "-1 gt -2");
		drive_cycle(1'b1, fp_cmp_pkg::op_lt, NEG_TWO, NEG_ONE, 1'b0, "-2 lt -1");
		drive_cycle(1'b1, fp_cmp_pkg::op_lt, NEG_ONE, POS_ONE, 1'b0, "-1 lt +1");
		drive_cycle(1'b1, fp_cmp_pkg::op_lt, POS_ONE, POS_TWO, 1'b0, "+1 lt +2");
		idle_cycles(2, 1'b0);

		// every opcode against a quiet and a signaling NaN.
		for (int k = 0; k < 8; k++) begin
			drive_cycle(1'b1, fp_cmp_pkg::cmp_op_e'(k), QNAN, POS_ONE, 1'b0,
				$sformatf("qnan op %0d", k));
			drive_cycle(1'b1, fp_cmp_pkg::cmp_op_e'(k), NEG_INF, SNAN, 1'b0,
				$sformatf("snan op %0d", k));
		end
		idle_cycles(2, 1'b0);

		// the sticky flag is cleared, set by a NaN, held, and cleared again.
		idle_cycles(1, 1'b1);
		idle_cycles(2, 1'b0);
		drive_cycle(1'b1, fp_cmp_pkg::op_lt, SNAN, POS_ONE, 1'b0, "sticky set");
		idle_cycles(3, 1'b0);
		drive_cycle(1'b1, fp_cmp_pkg::op_lt, POS_ONE, POS_TWO, 1'b0, "sticky hold");
		idle_cycles(2, 1'b0);
		idle_cycles(1, 1'b1);
		idle_cycles(2, 1'b0);
		// the clear is sampled on the edge that delivers this NaN result.
		drive_cycle(1'b1, fp_cmp_pkg::op_eq, QNAN, QNAN, 1'b0, "sticky set beats clear");
		idle_cycles(1, 1'b1);
		idle_cycles(2, 1'b0);

		// random pairs, mostly back to back with an occasional gap or clear.
		for (int k = 0; k < N_RANDOM; k++) begin
			r    = $random(seed);
			op_r = fp_cmp_pkg::cmp_op_e'(r[2:0]);
			b_r  = $random(seed);
			pick_operand(b_r, a_r);
			pick_operand(a_r, b_r);
			drive_cycle(1'b1, op_r, a_r, b_r, r[9:6] == 4'd0, $sformatf("random %0d", k));
			if (r[5:4] == 2'd0) begin
				idle_cycles(1, 1'b0);
			end
		end
		idle_cycles(3, 1'b0);

		if (exp_res_q.size() != 0) begin
			n_errors++;
			$display("%0d expected results never came out of the DUT", exp_res_q.size());
		end
		if (n_errors == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("=== FAIL ===");
			$fatal(1, "results missing at the end of the run");
		end
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+src
src/fp_cmp_pkg.sv
src/fp_decomp.sv
src/fp_cmp_unit.sv
src/fp_cmp_top.sv
tb/tb_clk_gen.sv
tb/tb_fp_cmp.sv

// File: Bender.yml
package:
  name: fp_cmp

sources:
  # design sources in compile order
  - include_dirs:
      - src
    files:
      - src/fp_cmp_pkg.sv
      - src/fp_decomp.sv
      - src/fp_cmp_unit.sv
      - src/fp_cmp_top.sv

  # testbench, top module tb_fp_cmp
  - target: test
    include_dirs:
      - src
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_fp_cmp.sv
